// File: design/sram_pkg.sv
package sram_pkg;

    localparam int SRAM_AW = 18;             // word address bits
    localparam int SRAM_DW = 16;             // data bus bits
    localparam int SRAM_BW = SRAM_DW / 8;    // byte lanes

    typedef logic [SRAM_AW-1:0] sram_addr_t;
    typedef logic [SRAM_DW-1:0] sram_data_t;
    typedef logic [SRAM_BW-1:0] sram_be_t;

    // one access request towards the arbiter
    typedef struct packed {
        sram_addr_t addr;
        logic       write;   // 1 for a write, 0 for a read
        sram_data_t wdata;   // don't care on reads
    } sram_req_t;

endpackage

// File: design/video_pkg.sv
package video_pkg;

    // horizontal timing in pixels
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 24

    // vertical timing in lines
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 12

    localparam int PIXEL_DIV     = 2;   // sys_clk cycles per pixel
    localparam int WRITE_CREDITS = 4;   // host write queue depth

    localparam int COLOR_W = 4;                      // bits per color component
    localparam int PIXELS  = H_ACTIVE * V_ACTIVE;    // 128

    typedef logic [3*COLOR_W-1:0]               rgb_t;          // {r, g, b}
    typedef logic [$clog2(PIXELS)-1:0]          pixel_addr_t;   // row * H_ACTIVE + col
    typedef logic [$clog2(H_TOTAL)-1:0]         hcount_t;
    typedef logic [$clog2(V_TOTAL)-1:0]         vcount_t;
    typedef logic [$clog2(PIXEL_DIV)-1:0]       pix_div_t;
    typedef logic [$clog2(WRITE_CREDITS)-1:0]   wq_ptr_t;
    typedef logic [$clog2(WRITE_CREDITS+1)-1:0] wq_count_t;

    // one pixel write from the host
    typedef struct packed {
        pixel_addr_t addr;
        rgb_t        rgb;
    } pix_write_t;

endpackage

// File: design/pixel_write_port.sv
`timescale 1ns/1ps

module pixel_write_port
    import sram_pkg::*, video_pkg::*;
(
    input  logic       sys_clk,
    input  logic       reset,

    // host side, credit controlled
    input  logic       wr_valid,
    input  pix_write_t wr_pixel,
    output logic       wr_credit,

    // towards the arbiter
    output logic       wreq_valid,
    output sram_req_t  wreq,
    input  logic       wreq_grant
);

    pix_write_t queue_mem [WRITE_CREDITS];   // qualified by count
    wq_ptr_t    wr_ptr;
    wq_ptr_t    rd_ptr;
    wq_count_t  count;
    pix_write_t head;
    logic       push;
    logic       pop;

    assign push = wr_valid;     // host only sends while it holds a credit
    assign pop  = wreq_grant;

    always_ff @(posedge sys_clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= wr_pixel;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credit goes back while the granted write is on the pins
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_credit <= 1'b0;
        end else begin
            wr_credit <= pop;
        end
    end

    // rgb sits in the low bits of the sram word
    assign head       = queue_mem[rd_ptr];
    assign wreq_valid = (count != '0);
    assign wreq       = '{addr:  sram_addr_t'(head.addr),
                          write: 1'b1,
                          wdata: sram_data_t'(head.rgb)};

    // a push into a full queue means the host overspent its credits
    a_no_overflow: assert property (@(posedge sys_clk) disable iff (reset)
        push |-> (count < wq_count_t'(WRITE_CREDITS)))
        else $error("write queue overflow, host credit violation");

endmodule

// File: design/sram_arbiter.sv
`timescale 1ns/1ps

module sram_arbiter
    import sram_pkg::*;
(
    input  logic            sys_clk,
    input  logic            reset,

    // scan-out reads, always granted
    input  logic            rreq_valid,
    input  sram_req_t       rreq,

    // host writes, served when no read is pending
    input  logic            wreq_valid,
    input  sram_req_t       wreq,
    output logic            wreq_grant,

    output logic            rdata_valid,
    output sram_data_t      rdata,

    // async sram pins
    output logic            sram_ce_n,
    output logic            sram_oe_n,
    output logic            sram_we_n,
    output sram_be_t        sram_be_n,
    output sram_addr_t      sram_addr,
    inout  wire sram_data_t sram_dq
);

    sram_req_t  sel;
    logic       sel_valid;
    sram_data_t wdata_q;

    // scan-out has priority, write only goes in a free cycle
    assign sel        = rreq_valid ? rreq : wreq;
    assign sel_valid  = rreq_valid || wreq_valid;
    assign wreq_grant = wreq_valid && !rreq_valid;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sram_ce_n   <= 1'b1;
            sram_oe_n   <= 1'b1;
            sram_we_n   <= 1'b1;
            sram_be_n   <= '1;
            rdata_valid <= 1'b0;
        end else begin
            sram_ce_n   <= !sel_valid;
            sram_oe_n   <= !(sel_valid && !sel.write);
            sram_we_n   <= !(sel_valid && sel.write);
            sram_be_n   <= {SRAM_BW{!sel_valid}};   // full words only
            rdata_valid <= !sram_oe_n;              // one cycle after the read on the pins
        end
    end

    always_ff @(posedge sys_clk) begin
        sram_addr <= sel.addr;
        wdata_q   <= sel.wdata;
        if (!sram_oe_n) begin
            rdata <= sram_dq;   // sample at the end of the read cycle
        end
    end

    // bus is ours only during a write cycle
    assign sram_dq = !sram_we_n ? wdata_q : 'z;

    a_no_bus_fight: assert property (@(posedge sys_clk) disable iff (reset)
        !(!sram_we_n && !sram_oe_n))
        else $error("sram we_n and oe_n low together");

endmodule

// File: design/vga_scanout.sv
`timescale 1ns/1ps

module vga_scanout
    import sram_pkg::*, video_pkg::*;
(
    input  logic               sys_clk,
    input  logic               reset,

    // read port into the arbiter
    output logic               rreq_valid,
    output sram_req_t          rreq,
    input  logic               rdata_valid,
    input  sram_data_t         rdata,

    // vga pins, all registered on the pixel strobe
    output logic [COLOR_W-1:0] vga_r,
    output logic [COLOR_W-1:0] vga_g,
    output logic [COLOR_W-1:0] vga_b,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output logic               vga_de
);

    typedef enum logic [1:0] {
        SCAN_FETCH,   // idle, waiting for an active pixel to prefetch
        SCAN_WAIT,    // read on the sram pins
        SCAN_SHOW     // data back, loaded on this strobe
    } scan_state_t;

    scan_state_t scan_state;
    scan_state_t scan_next;
    pix_div_t    pix_div;
    logic        pix_stb;
    hcount_t     h_count;
    hcount_t     h_next;
    vcount_t     v_count;
    vcount_t     v_next;
    logic        cur_active;
    logic        next_active;
    logic        hsync_on;
    logic        vsync_on;
    logic        fetch;
    pixel_addr_t fetch_addr;
    rgb_t        rgb_q;

    assign pix_stb = (pix_div == pix_div_t'(PIXEL_DIV - 1));

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            pix_div <= '0;
        end else if (pix_stb) begin
            pix_div <= '0;
        end else begin
            pix_div <= pix_div + 1'b1;
        end
    end

    // raster position after this strobe
    always_comb begin
        h_next = h_count + 1'b1;
        v_next = v_count;
        if (h_count == hcount_t'(H_TOTAL - 1)) begin
            h_next = '0;
            v_next = (v_count == vcount_t'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
        end
    end

    // start on the last blank pixel so pixel 0 gets its prefetch
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            h_count <= hcount_t'(H_TOTAL - 1);
            v_count <= vcount_t'(V_TOTAL - 1);
        end else if (pix_stb) begin
            h_count <= h_next;
            v_count <= v_next;
        end
    end

    assign cur_active  = (h_count < hcount_t'(H_ACTIVE)) && (v_count < vcount_t'(V_ACTIVE));
    assign next_active = (h_next < hcount_t'(H_ACTIVE)) && (v_next < vcount_t'(V_ACTIVE));
    assign hsync_on    = (h_count >= hcount_t'(H_ACTIVE + H_FRONT)) &&
                         (h_count < hcount_t'(H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync_on    = (v_count >= vcount_t'(V_ACTIVE + V_FRONT)) &&
                         (v_count < vcount_t'(V_ACTIVE + V_FRONT + V_SYNC));

    // read for the next pixel leaves two cycles before its strobe
    assign fetch      = pix_stb && next_active && (scan_state != SCAN_WAIT);
    assign fetch_addr = pixel_addr_t'(v_next * H_ACTIVE + h_next);
    assign rreq_valid = fetch;
    assign rreq       = '{addr: sram_addr_t'(fetch_addr), write: 1'b0, wdata: '0};

    always_comb begin
        scan_next = scan_state;
        case (scan_state)
            SCAN_FETCH: if (fetch) scan_next = SCAN_WAIT;
            SCAN_WAIT:  scan_next = SCAN_SHOW;   // next cycle is the strobe
            SCAN_SHOW:  scan_next = fetch ? SCAN_WAIT : SCAN_FETCH;
            default:    scan_next = SCAN_FETCH;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            scan_state <= SCAN_FETCH;
        end else begin
            scan_state <= scan_next;
        end
    end

    // returned pixel goes straight into the output register
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            rgb_q     <= '0;
        end else if (pix_stb) begin
            vga_hsync <= !hsync_on;   // active low
            vga_vsync <= !vsync_on;
            vga_de    <= cur_active;
            rgb_q     <= (scan_state == SCAN_SHOW) ? rgb_t'(rdata) : '0;   // black in blanking
        end
    end

    assign vga_r = rgb_q[3*COLOR_W-1 -: COLOR_W];
    assign vga_g = rgb_q[2*COLOR_W-1 -: COLOR_W];
    assign vga_b = rgb_q[COLOR_W-1:0];

    a_data_pending: assert property (@(posedge sys_clk) disable iff (reset)
        rdata_valid |-> (scan_state == SCAN_SHOW))
        else $error("read data without a pending fetch");

    // arbiter read latency has to line up with the strobe
    a_data_on_time: assert property (@(posedge sys_clk) disable iff (reset)
        (scan_state == SCAN_SHOW) |-> rdata_valid)
        else $error("prefetched pixel missing at its strobe");

endmodule

// File: design/frame_buffer_top.sv
`timescale 1ns/1ps

module frame_buffer_top
    import sram_pkg::*, video_pkg::*;
(
    input  logic               sys_clk,
    input  logic               reset,

    // host drawing port
    input  logic               wr_valid,
    input  pix_write_t         wr_pixel,
    output logic               wr_credit,

    // sram pins
    output logic               sram_ce_n,
    output logic               sram_oe_n,
    output logic               sram_we_n,
    output sram_be_t           sram_be_n,
    output sram_addr_t         sram_addr,
    inout  wire sram_data_t    sram_dq,

    // vga pins
    output logic [COLOR_W-1:0] vga_r,
    output logic [COLOR_W-1:0] vga_g,
    output logic [COLOR_W-1:0] vga_b,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output logic               vga_de
);

    logic       wreq_valid;
    logic       wreq_grant;
    sram_req_t  wreq;
    logic       rreq_valid;
    sram_req_t  rreq;
    logic       rdata_valid;
    sram_data_t rdata;

    pixel_write_port u_write_port (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .wr_valid   (wr_valid),
        .wr_pixel   (wr_pixel),
        .wr_credit  (wr_credit),
        .wreq_valid (wreq_valid),
        .wreq       (wreq),
        .wreq_grant (wreq_grant)
    );

    sram_arbiter u_arbiter (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .rreq_valid  (rreq_valid),
        .rreq        (rreq),
        .wreq_valid  (wreq_valid),
        .wreq        (wreq),
        .wreq_grant  (wreq_grant),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .sram_ce_n   (sram_ce_n),
        .sram_oe_n   (sram_oe_n),
        .sram_we_n   (sram_we_n),
        .sram_be_n   (sram_be_n),
        .sram_addr   (sram_addr),
        .sram_dq     (sram_dq)
    );

    vga_scanout u_scanout (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .rreq_valid  (rreq_valid),
        .rreq        (rreq),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_de      (vga_de)
    );

endmodule

// File: dv/sram_model.sv
`timescale 1ns/1ps

module sram_model
    import sram_pkg::*;
(
    input  logic            ce_n,
    input  logic            oe_n,
    input  logic            we_n,
    input  sram_be_t        be_n,
    input  sram_addr_t      addr,
    inout  wire sram_data_t dq
);

    sram_data_t mem [2**SRAM_AW];

    initial begin
        for (int i = 0; i < 2**SRAM_AW; i++) begin
            mem[i] = '0;   // powers up cleared
        end
    end

    // drives the bus only while output enabled and not writing
    assign dq = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

    // level sensitive write, follows addr and data while we_n is low
    always @(ce_n, we_n, be_n, addr, dq) begin
        if (!ce_n && !we_n) begin
            for (int lane = 0; lane < SRAM_BW; lane++) begin
                if (!be_n[lane]) begin
                    mem[addr][8*lane +: 8] = dq[8*lane +: 8];
                end
            end
        end
    end

endmodule

// File: dv/frame_buffer_tb.sv
`timescale 1ns/1ps

module frame_buffer_tb
    import sram_pkg::*, video_pkg::*;
();

    logic               sys_clk;
    logic               reset;
    logic               wr_valid;
    pix_write_t         wr_pixel;
    logic               wr_credit;
    logic               sram_ce_n;
    logic               sram_oe_n;
    logic               sram_we_n;
    sram_be_t           sram_be_n;
    sram_addr_t         sram_addr;
    wire sram_data_t    sram_dq;
    logic [COLOR_W-1:0] vga_r;
    logic [COLOR_W-1:0] vga_g;
    logic [COLOR_W-1:0] vga_b;
    logic               vga_hsync;
    logic               vga_vsync;
    logic               vga_de;

    // commands from the data file
    byte         cmd_q [$];
    pixel_addr_t addr_q [$];
    rgb_t        rgb_q [$];

    rgb_t shadow [PIXELS];      // last value written per pixel
    rgb_t frame_pix [PIXELS];   // active pixels of the frame being captured
    int   writes_sent;
    int   credits_back;
    int   fall_count;          // vsync falling edges seen
    int   frames_done;         // fall_count of the last complete capture
    int   pix_idx;
    int   hsync_low;
    int   vsync_low;
    int   de_run;
    int   de_lines;
    logic vsync_prev;
    int   cycle_count;
    int   cycle_limit;
    int   pixel_errors;
    int   sync_errors;
    int   credit_errors;
    int   file_errors;

    frame_buffer_top i_frame_buffer_top (.*);

    sram_model u_sram_model (
        .ce_n (sram_ce_n),
        .oe_n (sram_oe_n),
        .we_n (sram_we_n),
        .be_n (sram_be_n),
        .addr (sram_addr),
        .dq   (sram_dq)
    );

    initial sys_clk = 1'b0;
    always #4 sys_clk = ~sys_clk;   // 8 ns period

    task automatic load_commands();
        int               fd;
        int               code;
        int               addr;
        int               rgb;
        logic [63:0]      tok;
        logic [8*160-1:0] rest;
        fd = $fopen("dv/frame_buffer_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/frame_buffer_testdata.txt for reading");
            file_errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);   // rest of a comment line
                end else if (tok == "W") begin
                    code = $fscanf(fd, "%h %h", addr, rgb);
                    if (code != 2 || addr >= PIXELS) begin
                        $display("malformed write command in the data file");
                        file_errors++;
                    end else begin
                        cmd_q.push_back("W");
                        addr_q.push_back(pixel_addr_t'(addr));
                        rgb_q.push_back(rgb_t'(rgb));
                    end
                end else if (tok == "F") begin
                    cmd_q.push_back("F");
                    addr_q.push_back('0);
                    rgb_q.push_back('0);
                end else begin
                    $display("unknown command in the data file");
                    file_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // waits for a credit, then holds the write on the port for one cycle
    task automatic send_write(input pixel_addr_t pix_addr, input rgb_t pix_rgb);
        while (writes_sent - credits_back >= WRITE_CREDITS) begin
            wr_valid = 1'b0;
            @(posedge sys_clk);
            #1;
        end
        wr_valid = 1'b1;
        wr_pixel = '{addr: pix_addr, rgb: pix_rgb};
        writes_sent++;
        shadow[pix_addr] = pix_rgb;
        @(posedge sys_clk);
        #1;
    endtask

    task automatic compare_frame(input int check_no);
        int start;
        int i;
        wr_valid = 1'b0;
        wait (credits_back == writes_sent);
        start = fall_count;
        wait (frames_done > start);   // full frame after the next vsync fall
        for (i = 0; i < PIXELS; i++) begin
            if (frame_pix[i] !== shadow[i]) begin
                $display("ERROR %0t: frame check %0d row %0d col %0d got %h expected %h",
                         $time, check_no, i / H_ACTIVE, i % H_ACTIVE, frame_pix[i], shadow[i]);
                pixel_errors++;
            end
        end
        $display("frame check %0d compared %0d pixels", check_no, PIXELS);
        @(posedge sys_clk);
        #1;
    endtask

    task automatic verify_reset_values();
        if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || vga_de !== 1'b0 ||
            {vga_r, vga_g, vga_b} !== 12'h000) begin
            $display("ERROR %0t: vga after reset hsync %b vsync %b de %b rgb %h",
                     $time, vga_hsync, vga_vsync, vga_de, {vga_r, vga_g, vga_b});
            sync_errors++;
        end
        if (sram_ce_n !== 1'b1 || sram_oe_n !== 1'b1 || sram_we_n !== 1'b1 ||
            wr_credit !== 1'b0) begin
            $display("ERROR %0t: after reset ce_n %b oe_n %b we_n %b credit %b",
                     $time, sram_ce_n, sram_oe_n, sram_we_n, wr_credit);
            sync_errors++;
        end
    endtask

    task automatic report_counts();
        $display("errors: pixel %0d, sync %0d, credit %0d, data file %0d (writes %0d, credits %0d)",
                 pixel_errors, sync_errors, credit_errors, file_errors,
                 writes_sent, credits_back);
    endtask

    // outputs only change on rising edges, so look at them on falling ones
    always @(negedge sys_clk) begin
        if (!reset) begin
            if (wr_credit) begin
                credits_back++;
            end
            if (credits_back > writes_sent) begin
                $display("ERROR %0t: %0d writes sent but %0d credits back",
                         $time, writes_sent, credits_back);
                credit_errors++;
            end
            if (!vga_hsync) begin
                hsync_low++;
            end else begin
                if (hsync_low != 0 && hsync_low != H_SYNC * PIXEL_DIV) begin
                    $display("ERROR %0t: hsync low for %0d cycles", $time, hsync_low);
                    sync_errors++;
                end
                hsync_low = 0;
            end
            if (!vga_vsync) begin
                vsync_low++;
            end else begin
                if (vsync_low != 0 && vsync_low != V_SYNC * H_TOTAL * PIXEL_DIV) begin
                    $display("ERROR %0t: vsync low for %0d cycles", $time, vsync_low);
                    sync_errors++;
                end
                vsync_low = 0;
            end
            if (vsync_prev && !vga_vsync) begin   // new frame capture starts here
                if (de_lines != V_ACTIVE) begin
                    $display("ERROR %0t: %0d active lines in frame", $time, de_lines);
                    sync_errors++;
                end
                de_lines = 0;
                fall_count++;
                pix_idx = 0;
            end
            vsync_prev = vga_vsync;
            if (vga_de) begin
                if (de_run % PIXEL_DIV == 0 && pix_idx < PIXELS) begin   // first cycle of a pixel
                    frame_pix[pix_idx] = {vga_r, vga_g, vga_b};
                    pix_idx++;
                    if (pix_idx == PIXELS) begin
                        frames_done = fall_count;
                    end
                end
                de_run++;
            end else begin
                if (de_run != 0) begin
                    if (de_run != H_ACTIVE * PIXEL_DIV) begin
                        $display("ERROR %0t: de high for %0d cycles", $time, de_run);
                        sync_errors++;
                    end
                    de_lines++;
                end
                de_run = 0;
                if ({vga_r, vga_g, vga_b} !== 12'h000) begin
                    $display("ERROR %0t: rgb %h while de is low", $time, {vga_r, vga_g, vga_b});
                    sync_errors++;
                end
            end
        end
    end

    always @(posedge sys_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timed out after %0d cycles without finishing the commands", cycle_count);
            report_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int frames;
        int writes;
        int checks;
        int i;
        reset         = 1'b1;
        wr_valid      = 1'b0;
        wr_pixel      = '0;
        writes_sent   = 0;
        credits_back  = 0;
        fall_count    = 0;
        frames_done   = 0;
        pix_idx       = PIXELS;   // no capture before the first vsync fall
        hsync_low     = 0;
        vsync_low     = 0;
        de_run        = 0;
        de_lines      = 0;
        vsync_prev    = 1'b1;
        cycle_count   = 0;
        pixel_errors  = 0;
        sync_errors   = 0;
        credit_errors = 0;
        file_errors   = 0;
        frames        = 0;
        writes        = 0;
        checks        = 0;
        for (i = 0; i < PIXELS; i++) begin
            shadow[i] = '0;
        end
        load_commands();
        for (i = 0; i < cmd_q.size(); i++) begin
            if (cmd_q[i] == "F") begin
                frames++;
            end else begin
                writes++;
            end
        end
        cycle_limit = (frames + 2) * H_TOTAL * V_TOTAL * PIXEL_DIV * 2 + 100 * writes;
        repeat (3) @(posedge sys_clk);
        #1;
        reset = 1'b0;
        @(negedge sys_clk);
        verify_reset_values();   // no pixel strobe yet
        @(posedge sys_clk);
        #1;
        for (i = 0; i < cmd_q.size(); i++) begin
            if (cmd_q[i] == "W") begin
                send_write(addr_q[i], rgb_q[i]);
            end else begin
                checks++;
                compare_frame(checks);
            end
        end
        wr_valid = 1'b0;
        wait (credits_back == writes_sent);
        report_counts();
        if (pixel_errors + sync_errors + credit_errors + file_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dv/frame_buffer_testdata.txt
# W <pixel addr hex> <rgb hex>   pixel write, addr = row * 16 + col
# F                              compare a full frame with all writes so far
W 00 f00
W 01 0f0
W 02 00f
W 0f fff
W 10 123
W 1f 456
W 40 789
W 7f abc
F
W 20 111
W 20 222
W 20 333
W 21 a5a
W 20 5a5
W 55 0c3
W 6e 3c0
F
W 00 000
W 7f 001
F

// File: all.f
design/sram_pkg.sv
design/video_pkg.sv
design/pixel_write_port.sv
design/sram_arbiter.sv
design/vga_scanout.sv
design/frame_buffer_top.sv
dv/sram_model.sv
dv/frame_buffer_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := frame_buffer_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
